//--- uf_decoder_top.f
+incdir+testbench
rtl/uf_pkg.sv
rtl/fabric_if.sv
rtl/neighbor_link.sv
rtl/processing_unit.sv
rtl/cluster_parity.sv
rtl/stage_controller.sv
rtl/axi_lite_regs.sv
rtl/uf_decoder_top.sv
testbench/uf_decoder_tb.sv

//--- run_sim.sh
#!/bin/sh
# Builds the testbench with Verilator and runs it
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f uf_decoder_top.f \
    --top-module uf_decoder_tb --Mdir obj_dir -o uf_decoder_sim

./obj_dir/uf_decoder_sim | tee sim.log

if grep -q "Simulation PASSED" sim.log; then
    echo "uf_decoder_tb: pass"
else
    echo "uf_decoder_tb: fail"
    exit 1
fi

//--- testbench/uf_model.svh
`ifndef UF_MODEL_SVH
`define UF_MODEL_SVH

// Fibonacci LFSR, taps 32 22 2 1
function automatic logic [31:0] lfsr_next(input logic [31:0] state);
    return {state[30:0], state[31] ^ state[21] ^ state[1] ^ state[0]};
endfunction

function automatic int grow_link(input int growth);
    return (growth + 1 > WEIGHT) ? WEIGHT : growth + 1;
endfunction

// Odd flags per run of units joined by grown interior links
function automatic logic [NUM_UNITS-1:0] model_odd(input logic [NUM_UNITS-1:0] syn,
                                                    input logic [NUM_LINKS-1:0] grown);
    logic [NUM_UNITS-1:0] odd;
    int first;
    int last;
    logic parity;
    logic touch;
    odd = '0;
    first = 0;
    while (first < NUM_UNITS) begin
        last = first;
        while (last < NUM_UNITS - 1 && grown[last+1]) begin
            last++;
        end
        parity = 1'b0;
        for (int i = first; i <= last; i++) begin
            parity = parity ^ syn[i];
        end
        touch = (first == 0 && grown[0]) || (last == NUM_UNITS - 1 && grown[NUM_LINKS-1]);
        for (int i = first; i <= last; i++) begin
            odd[i] = parity && !touch;
        end
        first = last + 1;
    end
    return odd;
endfunction

task automatic model_decode(input logic [NUM_UNITS-1:0] syn,
                            output logic [NUM_LINKS-1:0] grown,
                            output logic [NUM_UNITS*ADDRESS_WIDTH-1:0] roots,
                            output logic [ROUNDS_WIDTH-1:0] rounds);
    int growth [NUM_LINKS];
    logic [NUM_UNITS-1:0] odd;
    int root;
    grown = '0;
    rounds = '0;
    foreach (growth[l]) begin
        growth[l] = 0;
    end
    odd = model_odd(syn, grown);
    while (odd != '0 && rounds < 8'd100) begin
        for (int u = 0; u < NUM_UNITS; u++) begin
            if (odd[u]) begin    // Unit u sits between links u and u+1
                growth[u] = grow_link(growth[u]);
                growth[u+1] = grow_link(growth[u+1]);
            end
        end
        for (int l = 0; l < NUM_LINKS; l++) begin
            grown[l] = (growth[l] >= WEIGHT);
        end
        rounds++;
        odd = model_odd(syn, grown);
    end
    // Lowest index of each run
    root = 0;
    for (int u = 0; u < NUM_UNITS; u++) begin
        if (u > 0 && !grown[u]) begin
            root = u;
        end
        roots[u*ADDRESS_WIDTH +: ADDRESS_WIDTH] = ADDRESS_WIDTH'(root);
    end
endtask

`endif

//--- testbench/uf_decoder_tb.sv
`timescale 1ns/10ps

module uf_decoder_tb import uf_pkg::*; ();

    localparam int TIMEOUT = 200;
    localparam int NUM_DECODES = 60;

    logic clk;
    logic reset;
    logic awvalid;
    logic awready;
    logic [AXI_ADDR_WIDTH-1:0] awaddr;
    logic wvalid;
    logic wready;
    logic [AXI_DATA_WIDTH-1:0] wdata;
    logic bvalid;
    logic bready;
    logic [1:0] bresp;
    logic arvalid;
    logic arready;
    logic [AXI_ADDR_WIDTH-1:0] araddr;
    logic rvalid;
    logic rready;
    logic [AXI_DATA_WIDTH-1:0] rdata;
    logic [1:0] rresp;

    logic [31:0] lfsr_state;
    logic [NUM_UNITS-1:0] current_syndrome;
    int error_count;
    int timeout_count;
    int writes_issued;
    int reads_issued;
    int b_seen;
    int r_seen;

    `include "uf_model.svh"

    uf_decoder_top dut0 (.*);

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // Handshakes seen on the bus
    always @(posedge clk) begin
        if (reset) begin
            b_seen <= 0;
            r_seen <= 0;
        end else begin
            if (bvalid && bready) b_seen <= b_seen + 1;
            if (rvalid && rready) r_seen <= r_seen + 1;
        end
    end

    function automatic logic [31:0] random_bits(input int count);
        logic [31:0] value;
        value = '0;
        for (int i = 0; i < count; i++) begin
            lfsr_state = lfsr_next(lfsr_state);
            value = {value[30:0], lfsr_state[0]};
        end
        return value;
    endfunction

    task automatic step();
        @(posedge clk);
        #10;
    endtask

    task automatic report_timeout(input string what);
        timeout_count++;
        $display("Timeout after %0d cycles waiting for %s", TIMEOUT, what);
    endtask

    task automatic check_grown(input logic [NUM_LINKS-1:0] got, input logic [NUM_LINKS-1:0] exp);
        if (got !== exp) begin
            error_count++;
            $display("FAILED grown: got 0x%h expected 0x%h syndrome 0x%h", got, exp,
                     current_syndrome);
        end
    endtask

    task automatic check_roots(input logic [NUM_UNITS*ADDRESS_WIDTH-1:0] got,
                               input logic [NUM_UNITS*ADDRESS_WIDTH-1:0] exp);
        if (got !== exp) begin
            error_count++;
            $display("FAILED roots: got 0x%h expected 0x%h syndrome 0x%h", got, exp,
                     current_syndrome);
        end
    endtask

    task automatic check_rounds(input logic [ROUNDS_WIDTH-1:0] got,
                                input logic [ROUNDS_WIDTH-1:0] exp);
        if (got !== exp) begin
            error_count++;
            $display("FAILED rounds: got 0x%h expected 0x%h syndrome 0x%h", got, exp,
                     current_syndrome);
        end
    endtask

    task automatic check_resp(input string name, input axi_resp_t got, input axi_resp_t exp);
        if (got !== exp) begin
            error_count++;
            $display("FAILED %s: got 0x%h expected 0x%h", name, got, exp);
        end
    endtask

    task automatic check_status(input logic [1:0] got, input logic [1:0] exp);
        if (got !== exp) begin
            error_count++;
            $display("FAILED status: got 0x%h expected 0x%h", got, exp);
        end
    endtask

    task automatic check_data(input string name, input logic [AXI_DATA_WIDTH-1:0] got,
                              input logic [AXI_DATA_WIDTH-1:0] exp);
        if (got !== exp) begin
            error_count++;
            $display("FAILED %s: got 0x%h expected 0x%h", name, got, exp);
        end
    endtask

    task automatic axi_write(input logic [AXI_ADDR_WIDTH-1:0] addr,
                             input logic [AXI_DATA_WIDTH-1:0] data, output axi_resp_t resp);
        int cycles;
        int stall;
        stall = int'(random_bits(2));
        step();
        awvalid = 1'b1;
        awaddr = addr;
        wvalid = 1'b1;
        wdata = data;
        cycles = 0;
        @(negedge clk);
        while (!(awready && wready) && cycles < TIMEOUT) begin
            cycles++;
            @(negedge clk);
        end
        if (cycles >= TIMEOUT) report_timeout("write address and data");
        step();     // Accepted on this edge
        awvalid = 1'b0;
        wvalid = 1'b0;
        writes_issued++;
        repeat (stall) step();
        bready = 1'b1;
        cycles = 0;
        @(negedge clk);
        while (!bvalid && cycles < TIMEOUT) begin
            cycles++;
            @(negedge clk);
        end
        if (cycles >= TIMEOUT) report_timeout("write response");
        resp = axi_resp_t'(bresp);
        step();
        bready = 1'b0;
        @(negedge clk);
        check_data("bvalid", 32'(bvalid), 32'h0);  // One response per write
    endtask

    task automatic axi_read(input logic [AXI_ADDR_WIDTH-1:0] addr,
                            output logic [AXI_DATA_WIDTH-1:0] data, output axi_resp_t resp);
        int cycles;
        int stall;
        stall = int'(random_bits(2));
        step();
        arvalid = 1'b1;
        araddr = addr;
        cycles = 0;
        @(negedge clk);
        while (!arready && cycles < TIMEOUT) begin
            cycles++;
            @(negedge clk);
        end
        if (cycles >= TIMEOUT) report_timeout("read address");
        step();
        arvalid = 1'b0;
        reads_issued++;
        repeat (stall) step();
        rready = 1'b1;
        cycles = 0;
        @(negedge clk);
        while (!rvalid && cycles < TIMEOUT) begin
            cycles++;
            @(negedge clk);
        end
        if (cycles >= TIMEOUT) report_timeout("read data");
        data = rdata;
        resp = axi_resp_t'(rresp);
        step();
        rready = 1'b0;
        @(negedge clk);
        check_data("rvalid", 32'(rvalid), 32'h0);
    endtask

    task automatic wait_done();
        logic [AXI_DATA_WIDTH-1:0] data;
        axi_resp_t resp;
        int polls;
        polls = 0;
        axi_read(REG_STATUS, data, resp);
        while (!data[1] && polls < TIMEOUT) begin
            polls++;
            axi_read(REG_STATUS, data, resp);
        end
        if (polls >= TIMEOUT) report_timeout("decode done");
        check_resp("rresp", resp, RESP_OKAY);
        check_status(data[1:0], 2'b10);
    endtask

    task automatic run_decode(input logic [NUM_UNITS-1:0] syn, input bit restart);
        axi_resp_t resp;
        logic [AXI_DATA_WIDTH-1:0] data;
        logic [NUM_LINKS-1:0] exp_grown;
        logic [NUM_UNITS*ADDRESS_WIDTH-1:0] exp_roots;
        logic [ROUNDS_WIDTH-1:0] exp_rounds;
        current_syndrome = syn;
        model_decode(syn, exp_grown, exp_roots, exp_rounds);
        axi_write(REG_SYNDROME, AXI_DATA_WIDTH'(syn), resp);
        check_resp("bresp", resp, RESP_OKAY);
        axi_write(REG_CONTROL, 32'h1, resp);
        check_resp("bresp", resp, RESP_OKAY);
        if (restart) begin
            axi_read(REG_STATUS, data, resp);
            check_status(data[1:0], 2'b01);
            // A reload would pick up this syndrome
            axi_write(REG_SYNDROME, AXI_DATA_WIDTH'(~syn), resp);
            check_resp("bresp", resp, RESP_OKAY);
            axi_write(REG_CONTROL, 32'h1, resp);
            check_resp("bresp", resp, RESP_OKAY);
        end
        wait_done();
        axi_read(REG_GROWN, data, resp);
        check_resp("rresp", resp, RESP_OKAY);
        check_grown(data[NUM_LINKS-1:0], exp_grown);
        axi_read(REG_ROOTS, data, resp);
        check_roots(data[NUM_UNITS*ADDRESS_WIDTH-1:0], exp_roots);
        axi_read(REG_ROUNDS, data, resp);
        check_rounds(data[ROUNDS_WIDTH-1:0], exp_rounds);
    endtask

    initial begin
        logic [AXI_DATA_WIDTH-1:0] data;
        logic [31:0] rnd;
        axi_resp_t resp;
        lfsr_state = 32'hf471;
        current_syndrome = '0;
        error_count = 0;
        timeout_count = 0;
        writes_issued = 0;
        reads_issued = 0;
        reset = 1'b1;
        awvalid = 1'b0;
        awaddr = '0;
        wvalid = 1'b0;
        wdata = '0;
        bready = 1'b0;
        arvalid = 1'b0;
        araddr = '0;
        rready = 1'b0;
        repeat (16) @(posedge clk);
        #10;
        reset = 1'b0;

        axi_read(REG_STATUS, data, resp);
        check_resp("rresp", resp, RESP_OKAY);
        check_status(data[1:0], 2'b00);
        axi_read(REG_GROWN, data, resp);
        check_grown(data[NUM_LINKS-1:0], '0);

        // Empty syndrome needs no growth
        run_decode(8'h00, 1'b0);
        axi_read(REG_ROUNDS, data, resp);
        check_rounds(data[ROUNDS_WIDTH-1:0], '0);
        axi_read(REG_GROWN, data, resp);
        check_grown(data[NUM_LINKS-1:0], '0);

        for (int d = 0; d < NUM_DECODES && timeout_count == 0; d++) begin
            rnd = random_bits(NUM_UNITS);
            run_decode(rnd[NUM_UNITS-1:0], 1'b0);
        end

        run_decode(8'h10, 1'b1);   // Long decode, second start lands mid run

        axi_read(8'h20, data, resp);
        check_resp("rresp", resp, RESP_SLVERR);
        check_data("rdata", data, '0);
        axi_write(8'h3C, 32'h1, resp);
        check_resp("bresp", resp, RESP_SLVERR);

        step();
        if (b_seen != writes_issued || r_seen != reads_issued) begin
            error_count++;
            $display("Response count mismatch: %0d of %0d writes and %0d of %0d reads answered",
                     b_seen, writes_issued, r_seen, reads_issued);
        end

        $display("Errors: %0d mismatches, %0d timeouts", error_count, timeout_count);
        if (error_count == 0 && timeout_count == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

endmodule

//--- rtl/uf_decoder_top.sv
`timescale 1ns/10ps

module uf_decoder_top import uf_pkg::*; (
    input logic clk,
    input logic reset,
    input logic awvalid,
    output logic awready,
    input logic [AXI_ADDR_WIDTH-1:0] awaddr,
    input logic wvalid,
    output logic wready,
    input logic [AXI_DATA_WIDTH-1:0] wdata,
    output logic bvalid,
    input logic bready,
    output logic [1:0] bresp,
    input logic arvalid,
    output logic arready,
    input logic [AXI_ADDR_WIDTH-1:0] araddr,
    output logic rvalid,
    input logic rready,
    output logic [AXI_DATA_WIDTH-1:0] rdata,
    output logic [1:0] rresp
);

    logic start;
    logic busy;
    logic done;
    logic [NUM_UNITS-1:0] syndrome;
    logic [ROUNDS_WIDTH-1:0] rounds;
    logic [NUM_UNITS-1:0] increase;
    logic [NUM_UNITS-1:0][ADDRESS_WIDTH-1:0] roots;   // Unit i in bits 3i+2:3i
    logic [NUM_UNITS-1:0][ADDRESS_WIDTH-1:0] left_root;
    logic [NUM_UNITS-1:0][ADDRESS_WIDTH-1:0] right_root;

    fabric_if fab ();

    axi_lite_regs regs0 (
        .clk, .reset,
        .awvalid, .awready, .awaddr, .wvalid, .wready, .wdata,
        .bvalid, .bready, .bresp,
        .arvalid, .arready, .araddr, .rvalid, .rready, .rdata, .rresp,
        .start, .syndrome, .busy, .done,
        .grown(fab.grown), .roots(roots), .rounds
    );

    stage_controller ctrl0 (
        .clk, .reset, .start, .ctrl(fab.control), .busy, .done, .rounds
    );

    cluster_parity parity0 (
        .fab(fab.parity)
    );

    for (genvar i = 0; i < NUM_UNITS; i++) begin : g_unit
        processing_unit #(.INDEX(i)) unit (
            .clk, .reset,
            .global_stage(fab.global_stage),
            .defect_in(syndrome[i]),
            .defect(fab.defects[i]),
            .odd(fab.odd[i]),
            .increase(increase[i]),
            .left_grown(fab.grown[i]),
            .right_grown(fab.grown[i+1]),
            .left_root(left_root[i]),
            .right_root(right_root[i]),
            .root(roots[i]),
            .root_changed(fab.root_changed[i])
        );
    end

    // End units sit on the a side of their boundary link
    for (genvar i = 0; i < NUM_LINKS; i++) begin : g_link
        if (i == 0) begin : g_left
            neighbor_link #(.BOUNDARY_CONDITION(1)) link (
                .clk, .reset, .global_stage(fab.global_stage),
                .a_increase(increase[0]), .b_increase(1'b0),
                .a_root_in(roots[0]), .b_root_in('0),
                .a_root_out(left_root[0]), .b_root_out(),
                .fully_grown(fab.grown[i]), .is_boundary()
            );
        end else if (i == NUM_LINKS - 1) begin : g_right
            neighbor_link #(.BOUNDARY_CONDITION(1)) link (
                .clk, .reset, .global_stage(fab.global_stage),
                .a_increase(increase[NUM_UNITS-1]), .b_increase(1'b0),
                .a_root_in(roots[NUM_UNITS-1]), .b_root_in('0),
                .a_root_out(right_root[NUM_UNITS-1]), .b_root_out(),
                .fully_grown(fab.grown[i]), .is_boundary()
            );
        end else begin : g_inner
            neighbor_link #(.BOUNDARY_CONDITION(0)) link (
                .clk, .reset, .global_stage(fab.global_stage),
                .a_increase(increase[i-1]), .b_increase(increase[i]),
                .a_root_in(roots[i-1]), .b_root_in(roots[i]),
                .a_root_out(right_root[i-1]), .b_root_out(left_root[i]),
                .fully_grown(fab.grown[i]), .is_boundary()
            );
        end
    end

endmodule

//--- rtl/axi_lite_regs.sv
`timescale 1ns/10ps

module axi_lite_regs import uf_pkg::*; (
    input logic clk,
    input logic reset,
    input logic awvalid,
    output logic awready,
    input logic [AXI_ADDR_WIDTH-1:0] awaddr,
    input logic wvalid,
    output logic wready,
    input logic [AXI_DATA_WIDTH-1:0] wdata,
    output logic bvalid,
    input logic bready,
    output axi_resp_t bresp,
    input logic arvalid,
    output logic arready,
    input logic [AXI_ADDR_WIDTH-1:0] araddr,
    output logic rvalid,
    input logic rready,
    output logic [AXI_DATA_WIDTH-1:0] rdata,
    output axi_resp_t rresp,
    output logic start,
    output logic [NUM_UNITS-1:0] syndrome,
    input logic busy,
    input logic done,
    input logic [NUM_LINKS-1:0] grown,
    input logic [NUM_UNITS*ADDRESS_WIDTH-1:0] roots,
    input logic [ROUNDS_WIDTH-1:0] rounds
);

    logic write_accept;
    logic read_accept;
    logic write_known;
    logic [AXI_DATA_WIDTH-1:0] read_data;
    axi_resp_t read_resp;

    // Address and data are taken in the same cycle
    assign write_accept = awvalid && wvalid && !bvalid;
    assign awready = write_accept;
    assign wready = write_accept;
    assign read_accept = arvalid && !rvalid;
    assign arready = read_accept;

    assign write_known = awaddr inside {REG_CONTROL, REG_SYNDROME, REG_STATUS,
                                        REG_GROWN, REG_ROOTS, REG_ROUNDS};

    always_comb begin
        read_data = '0;
        read_resp = RESP_OKAY;
        case (araddr)
            REG_CONTROL: read_data = '0;    // Start is self clearing
            REG_SYNDROME: read_data = AXI_DATA_WIDTH'(syndrome);
            REG_STATUS: read_data = AXI_DATA_WIDTH'({done, busy});
            REG_GROWN: read_data = AXI_DATA_WIDTH'(grown);
            REG_ROOTS: read_data = AXI_DATA_WIDTH'(roots);
            REG_ROUNDS: read_data = AXI_DATA_WIDTH'(rounds);
            default: read_resp = RESP_SLVERR;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            bvalid <= 1'b0;
            bresp <= RESP_OKAY;
            start <= 1'b0;
            syndrome <= '0;
        end else begin
            start <= 1'b0;  // One cycle pulse
            if (write_accept) begin
                bvalid <= 1'b1;
                bresp <= write_known ? RESP_OKAY : RESP_SLVERR;
                if (awaddr == REG_CONTROL && wdata[0]) begin
                    start <= 1'b1;
                end
                if (awaddr == REG_SYNDROME) begin
                    syndrome <= wdata[NUM_UNITS-1:0];
                end
            end else if (bvalid && bready) begin
                bvalid <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            rvalid <= 1'b0;
            rresp <= RESP_OKAY;
        end else if (read_accept) begin
            rvalid <= 1'b1;
            rresp <= read_resp;
        end else if (rvalid && rready) begin
            rvalid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (read_accept) begin
            rdata <= read_data;
        end
    end

    a_bvalid_hold: assert property (
        @(posedge clk) disable iff (reset) bvalid && !bready |=> bvalid
    );

    a_rvalid_hold: assert property (
        @(posedge clk) disable iff (reset) rvalid && !rready |=> rvalid && $stable(rdata)
    );

endmodule

//--- rtl/stage_controller.sv
`timescale 1ns/10ps

module stage_controller import uf_pkg::*; (
    input logic clk,
    input logic reset,
    input logic start,
    fabric_if.control ctrl,
    output logic busy,
    output logic done,
    output logic [ROUNDS_WIDTH-1:0] rounds
);

    stage_t stage;
    stage_t stage_next;

    always_comb begin
        stage_next = stage;
        case (stage)
            STAGE_IDLE, STAGE_DONE: begin
                if (start) begin
                    stage_next = STAGE_MEASUREMENT_LOADING;
                end
            end
            STAGE_MEASUREMENT_LOADING: stage_next = STAGE_PARITY_CHECK;
            STAGE_PARITY_CHECK: begin
                stage_next = (|ctrl.odd) ? STAGE_GROW : STAGE_DONE;
            end
            STAGE_GROW: stage_next = STAGE_MERGE;
            STAGE_MERGE: begin
                // Stay until roots settle
                if (!(|ctrl.root_changed)) begin
                    stage_next = STAGE_PARITY_CHECK;
                end
            end
            default: stage_next = STAGE_IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            stage <= STAGE_IDLE;
            rounds <= '0;
        end else begin
            stage <= stage_next;
            if (stage == STAGE_MEASUREMENT_LOADING) begin
                rounds <= '0;
            end else if (stage == STAGE_GROW) begin
                rounds <= rounds + 1'b1;
            end
        end
    end

    assign ctrl.global_stage = stage;

    // Start pulse counts as busy before the stage moves
    assign busy = start || (stage != STAGE_IDLE && stage != STAGE_DONE);
    assign done = (stage == STAGE_DONE) && !start;

    a_stage_defined: assert property (
        @(posedge clk) disable iff (reset)
        stage inside {STAGE_IDLE, STAGE_MEASUREMENT_LOADING, STAGE_PARITY_CHECK,
                      STAGE_GROW, STAGE_MERGE, STAGE_DONE}
    );

endmodule

//--- rtl/cluster_parity.sv
`timescale 1ns/10ps

module cluster_parity import uf_pkg::*; (
    fabric_if.parity fab
);

    logic [NUM_UNITS-1:0] odd_flags;

    // Forward pass accumulates parity and left boundary contact along each run,
    // backward pass hands the totals to every unit of the run
    always_comb begin
        logic [NUM_UNITS-1:0] fwd_parity;
        logic [NUM_UNITS-1:0] fwd_touch;
        logic par;
        logic touch;

        par = 1'b0;
        touch = fab.grown[0];
        for (int i = 0; i < NUM_UNITS; i++) begin
            if (i > 0 && !fab.grown[i]) begin
                par = 1'b0;     // New cluster starts here
                touch = 1'b0;
            end
            par = par ^ fab.defects[i];
            fwd_parity[i] = par;
            fwd_touch[i] = touch;
        end

        par = fwd_parity[NUM_UNITS-1];
        touch = fwd_touch[NUM_UNITS-1] | fab.grown[NUM_LINKS-1];
        for (int i = NUM_UNITS - 1; i >= 0; i--) begin
            if (i < NUM_UNITS - 1 && !fab.grown[i+1]) begin
                par = fwd_parity[i];
                touch = fwd_touch[i];
            end
            odd_flags[i] = par & ~touch;
        end
    end

    assign fab.odd = odd_flags;

endmodule

//--- rtl/processing_unit.sv
`timescale 1ns/10ps

module processing_unit import uf_pkg::*; #(
    parameter int INDEX = 0
) (
    input logic clk,
    input logic reset,
    input stage_t global_stage,
    input logic defect_in,
    output logic defect,
    input logic odd,
    output logic increase,
    input logic left_grown,
    input logic right_grown,
    input logic [ADDRESS_WIDTH-1:0] left_root,
    input logic [ADDRESS_WIDTH-1:0] right_root,
    output logic [ADDRESS_WIDTH-1:0] root,
    output logic root_changed
);

    logic [ADDRESS_WIDTH-1:0] merged_root;

    // Smallest root reachable over one fully grown link.
    // End units never merge across their boundary link.
    always_comb begin
        merged_root = root;
        if (INDEX > 0 && left_grown && left_root < merged_root) begin
            merged_root = left_root;
        end
        if (INDEX < NUM_UNITS - 1 && right_grown && right_root < merged_root) begin
            merged_root = right_root;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            defect <= 1'b0;
            root <= ADDRESS_WIDTH'(INDEX);
        end else begin
            case (global_stage)
                STAGE_MEASUREMENT_LOADING: begin
                    defect <= defect_in;
                    root <= ADDRESS_WIDTH'(INDEX);  // Every unit starts as its own cluster
                end
                STAGE_MERGE: root <= merged_root;
                default: ;
            endcase
        end
    end

    assign root_changed = (merged_root != root);
    assign increase = odd && (global_stage == STAGE_GROW);

endmodule

//--- rtl/neighbor_link.sv
`timescale 1ns/10ps

module neighbor_link import uf_pkg::*; #(
    parameter int BOUNDARY_CONDITION = 0    // 0 interior, 1 boundary
) (
    input logic clk,
    input logic reset,
    input stage_t global_stage,
    input logic a_increase,
    input logic b_increase,
    input logic [ADDRESS_WIDTH-1:0] a_root_in,
    input logic [ADDRESS_WIDTH-1:0] b_root_in,
    output logic [ADDRESS_WIDTH-1:0] a_root_out,
    output logic [ADDRESS_WIDTH-1:0] b_root_out,
    output logic fully_grown,
    output logic is_boundary
);

    logic [GROWTH_WIDTH-1:0] growth;
    logic [GROWTH_WIDTH-1:0] growth_next;

    if (BOUNDARY_CONDITION == 1) begin : g_boundary
        // Only the end unit sits on the a side
        assign growth_next = growth + GROWTH_WIDTH'(a_increase);
        assign a_root_out = '0;
        assign b_root_out = '0;
        assign is_boundary = fully_grown;
    end else begin : g_interior
        logic [GROWTH_WIDTH:0] growth_sum;

        assign growth_sum = {1'b0, growth} + (GROWTH_WIDTH + 1)'(a_increase)
                          + (GROWTH_WIDTH + 1)'(b_increase);
        assign growth_next = (growth_sum > WEIGHT) ? GROWTH_WIDTH'(WEIGHT)
                                                   : growth_sum[GROWTH_WIDTH-1:0];
        assign a_root_out = b_root_in;  // Roots cross the edge
        assign b_root_out = a_root_in;
        assign is_boundary = 1'b0;
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            growth <= '0;
        end else if (global_stage == STAGE_MEASUREMENT_LOADING) begin
            growth <= '0;
        end else begin
            growth <= growth_next;
        end
    end

    assign fully_grown = (growth >= WEIGHT);

    a_growth_bounded: assert property (
        @(posedge clk) disable iff (reset) growth <= GROWTH_WIDTH'(WEIGHT)
    );

endmodule

//--- rtl/fabric_if.sv
`timescale 1ns/10ps

interface fabric_if import uf_pkg::*; ();

    logic [NUM_UNITS-1:0] defects;
    logic [NUM_LINKS-1:0] grown;        // Fully grown links
    logic [NUM_UNITS-1:0] odd;
    logic [NUM_UNITS-1:0] root_changed;
    stage_t global_stage;

    // Units and links
    modport fabric (
        input global_stage,
        input odd,
        output defects,
        output grown,
        output root_changed
    );

    modport parity (
        input defects,
        input grown,
        output odd
    );

    modport control (
        input odd,
        input root_changed,
        output global_stage
    );

endinterface

//--- rtl/uf_pkg.sv
package uf_pkg;

    // Decoding fabric sizes
    localparam int NUM_UNITS = 8;
    localparam int NUM_LINKS = 9;   // 0 and 8 are the boundary links
    localparam int WEIGHT = 2;
    localparam int ADDRESS_WIDTH = 3;
    localparam int GROWTH_WIDTH = 2;
    localparam int ROUNDS_WIDTH = 8;

    // AXI4-Lite bus
    localparam int AXI_ADDR_WIDTH = 8;
    localparam int AXI_DATA_WIDTH = 32;

    // Register byte addresses
    localparam logic [AXI_ADDR_WIDTH-1:0] REG_CONTROL = 8'h00;
    localparam logic [AXI_ADDR_WIDTH-1:0] REG_SYNDROME = 8'h04;
    localparam logic [AXI_ADDR_WIDTH-1:0] REG_STATUS = 8'h08;
    localparam logic [AXI_ADDR_WIDTH-1:0] REG_GROWN = 8'h0C;
    localparam logic [AXI_ADDR_WIDTH-1:0] REG_ROOTS = 8'h10;
    localparam logic [AXI_ADDR_WIDTH-1:0] REG_ROUNDS = 8'h14;

    typedef enum logic [2:0] {
        STAGE_IDLE,
        STAGE_MEASUREMENT_LOADING,
        STAGE_PARITY_CHECK,
        STAGE_GROW,
        STAGE_MERGE,
        STAGE_DONE
    } stage_t;

    typedef enum logic [1:0] {
        RESP_OKAY = 2'b00,
        RESP_SLVERR = 2'b10
    } axi_resp_t;

endpackage
